/* Makefile */
SIM     := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := tb_sld_unit
FLIST   := flist.f
OBJ_DIR := obj_dir
EXE     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(EXE)); echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* bench/sld_unit_assert.sv */
////////////////////////////////////////////////////////////
// port protocol checks, bound into every sld_unit instance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sld_unit_assert (
    input logic              clk_i,
    input logic              async_rst_ni,
    input sld_pkg::sld_cmd_t cmd_i,
    input logic              cmd_valid_i,
    input logic              cmd_ready_o,
    input sld_pkg::sld_wr_t  wr_o,
    input logic              wr_valid_o,
    input logic              wr_ready_i
);

    // a waiting command keeps its value until it is taken
    cmd_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        cmd_valid_i && !cmd_ready_o |=> cmd_valid_i && $stable(cmd_i))
        else $error("cmd_i changed while it waited for cmd_ready_o");

    // write held off by wr_ready_i
    wr_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_o))
        else $error("wr_o changed while it was stalled");

    reset_values: assert property (@(posedge clk_i)
        !async_rst_ni |-> !wr_valid_o && cmd_ready_o)
        else $error("handshake outputs left their reset values during reset");

endmodule

bind sld_unit sld_unit_assert u_sld_unit_assert (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .cmd_i        (cmd_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .wr_o         (wr_o),
    .wr_valid_o   (wr_valid_o),
    .wr_ready_i   (wr_ready_i)
);

/* bench/tb_clk_gen.sv */
////////////////////////////////////////////////////////////
// 10 ns clock, reset held low for the first 4 rising edges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic async_rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        async_rst_no = 1'b0;
        repeat (4) @(posedge clk_o);
        #1;
        async_rst_no = 1'b1;
    end

endmodule

/* bench/tb_sld_unit.sv */
////////////////////////////////////////////////////////////
// random slide commands checked against a byte model
// inputs change 1 ns after the rising edge and outputs are read at the falling edge
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sld_params.svh"

module tb_sld_unit;

    import sld_pkg::*;

    localparam int N_RAND      = 40;
    localparam int N_CMDS      = 5 * N_RAND;
    // 50 cycles of 10 ns per command plus reset and drain
    localparam int WATCHDOG_NS = (N_CMDS * 50 + 40) * 10;

    logic     clk_i;
    logic     async_rst_ni;
    sld_cmd_t cmd_i;
    logic     cmd_valid_i;
    logic     cmd_ready_o;
    sld_wr_t  wr_o;
    logic     wr_valid_o;
    logic     wr_ready_i;

    sld_wr_t  exp_q[$];
    logic     bp_on;

    tb_clk_gen u_clk_gen (
        .clk_o        (clk_i),
        .async_rst_no (async_rst_ni)
    );

    sld_unit sld_unit_i (
        .clk_i, .async_rst_ni, .cmd_i, .cmd_valid_i, .cmd_ready_o,
        .wr_o, .wr_valid_o, .wr_ready_i
    );

    task automatic end_with_fail();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [159:0] got,
                               input logic [159:0] want);
        if (got !== want) begin
            $display("Error: %s is %h, expected %h", name, got, want);
            end_with_fail();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model

    // an out-of-range slide-up leaves vd alone and sends no write
    function automatic bit has_write(input sld_cmd_t c);
        longint unsigned off;
        off = {32'd0, c.rs1} << int'(c.sew);
        return !(c.mode == SLD_UP && off >= 64'd16);
    endfunction

    function automatic sld_wr_t slide_model(input sld_cmd_t c);
        sld_wr_t         w;
        longint unsigned off;
        int              vl_b;
        w.addr = c.vd;
        w.data = '0;
        w.mask = '0;
        off    = {32'd0, c.rs1} << int'(c.sew);
        vl_b   = int'(c.vl) << int'(c.sew);
        for (int j = 0; j < `SLD_VMSK_W; j++) begin
            if (j < vl_b && c.mode == SLD_UP) begin
                if (64'(j) >= off) begin
                    w.mask[j]        = 1'b1;
                    w.data[j*8 +: 8] = c.vs2_data[(j - int'(off))*8 +: 8];
                end
            end else if (j < vl_b) begin
                // bytes from past the register end read as zero
                w.mask[j] = 1'b1;
                if (64'(j) + off < 64'd16) begin
                    w.data[j*8 +: 8] = c.vs2_data[(j + int'(off))*8 +: 8];
                end
            end
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus

    function automatic sld_cmd_t rand_cmd(input sld_mode_e mode, input bit in_range);
        sld_cmd_t c;
        int       lim;
        c.mode     = mode;
        c.sew      = sld_sew_e'(2'($urandom_range(2, 0)));
        c.vl       = 5'($urandom_range(16, 0));
        c.vd       = 5'($urandom);
        c.vs2_data = {$urandom, $urandom, $urandom, $urandom};
        lim        = 16 >> int'(c.sew);
        if (in_range) begin
            c.rs1 = $urandom_range(lim - 1, 0);
        end else if ($urandom_range(1, 0) == 0) begin
            c.rs1 = $urandom_range(lim + 7, lim);
        end else begin
            c.rs1 = $urandom | 32'h0000_0100;
        end
        return c;
    endfunction

    task automatic send_cmd(input sld_cmd_t c);
        cmd_i       = c;
        cmd_valid_i = 1'b1;
        do begin
            @(negedge clk_i);
        end while (!cmd_ready_o);
        if (has_write(c)) begin
            exp_q.push_back(slide_model(c));
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        cmd_valid_i = 1'b0;
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // random write back-pressure while enabled
    initial begin
        wr_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #1;
            wr_ready_i = bp_on ? 1'($urandom) : 1'b1;
        end
    end

    // writes are compared at mid-cycle
    initial begin
        sld_wr_t                want;
        sld_wr_t                held;
        logic                   stalled;
        logic [`SLD_VREG_W-1:0] keep;
        stalled = 1'b0;
        held    = '0;
        forever begin
            @(negedge clk_i);
            if (stalled) begin
                check_value("wr_valid_o", 160'(wr_valid_o), 160'd1);
                check_value("wr_o", 160'(wr_o), 160'(held));
            end
            if (wr_valid_o && wr_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("A write arrived with no command waiting for it");
                    end_with_fail();
                end else begin
                    want = exp_q.pop_front();
                    for (int b = 0; b < `SLD_VMSK_W; b++) begin
                        keep[b*8 +: 8] = {8{want.mask[b]}};
                    end
                    check_value("wr_o.addr", 160'(wr_o.addr), 160'(want.addr));
                    check_value("wr_o.mask", 160'(wr_o.mask), 160'(want.mask));
                    check_value("wr_o.data", 160'(wr_o.data & keep), 160'(want.data & keep));
                end
            end
            stalled = wr_valid_o & ~wr_ready_i;
            held    = wr_o;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the writes did not finish within %0d ns", WATCHDOG_NS);
        end_with_fail();
    end

    initial begin
        void'($urandom(32'hba16));
        cmd_i       = '0;
        cmd_valid_i = 1'b0;
        bp_on       = 1'b0;
        @(posedge async_rst_ni);
        @(posedge clk_i);
        #1;
        repeat (N_RAND) begin
            send_cmd(rand_cmd(SLD_UP, 1'b1));
            idle_cycles($urandom_range(3, 0));
        end
        repeat (N_RAND) begin
            send_cmd(rand_cmd(SLD_DOWN, 1'b1));
            idle_cycles($urandom_range(3, 0));
        end
        // out-of-range amounts in both directions
        for (int i = 0; i < N_RAND; i++) begin
            send_cmd(rand_cmd(sld_mode_e'(1'(i)), 1'b0));
            idle_cycles($urandom_range(2, 0));
        end
        bp_on = 1'b1;
        repeat (N_RAND) begin
            send_cmd(rand_cmd(sld_mode_e'(1'($urandom)), $urandom_range(3, 0) != 0));
            idle_cycles($urandom_range(2, 0));
        end
        // cmd_valid_i stays high from here on
        bp_on = 1'b0;
        repeat (N_RAND) begin
            send_cmd(rand_cmd(sld_mode_e'(1'($urandom)), $urandom_range(3, 0) != 0));
        end
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        // a late write with nothing expected still fails in the monitor
        repeat (20) @(posedge clk_i);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/sld_pkg.sv
hw/sld_ctrl_fsm.sv
hw/sld_beat_counter.sv
hw/sld_operand_stage.sv
hw/sld_byte_shifter.sv
hw/sld_result_assembler.sv
hw/sld_unit.sv
bench/tb_clk_gen.sv
bench/sld_unit_assert.sv
bench/tb_sld_unit.sv

/* hw/sld_beat_counter.sv */
////////////////////////////////////////////////////////////
// beat and store counters step together; a load wins
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sld_beat_counter (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               start_i,
    input  logic               step_i,
    input  sld_pkg::sld_beat_u store_init_i,
    output sld_pkg::sld_beat_u beat_o,
    output sld_pkg::sld_beat_u store_o,
    output logic               beat_last_o
);

    import sld_pkg::*;

    sld_beat_u beat_q;
    sld_beat_u store_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            beat_q.val  <= 3'd0;
            store_q.val <= 3'd0;
        end else if (start_i) begin
            beat_q.val  <= 3'd0;
            store_q     <= store_init_i;
        end else if (step_i) begin
            beat_q.val  <= beat_q.val + 3'd1;
            store_q.val <= store_q.val + 3'd1;
        end
    end

    // the extra beat after the last word drains the high operand
    assign beat_last_o = beat_q.part.mul & (beat_q.part.low == 2'b00);
    assign beat_o      = beat_q;
    assign store_o     = store_q;

endmodule

/* hw/sld_byte_shifter.sv */
////////////////////////////////////////////////////////////
// picks four result bytes from the low/high operand pair
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sld_params.svh"

module sld_byte_shifter (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  sld_pkg::sld_stage_t  stage_i,
    input  logic                 stage_valid_i,
    output logic                 stage_ready_o,
    input  logic [`SLD_OP_W-1:0] op_low_i,
    input  logic [`SLD_OP_W-1:0] op_high_i,
    output sld_pkg::sld_stage_t  stage_o,
    output logic                 stage_valid_o,
    input  logic                 stage_ready_i,
    output logic [`SLD_OP_W-1:0] result_o,
    output logic [3:0]           result_mask_o
);

    import sld_pkg::*;

    logic                 valid_q;
    sld_stage_t           stage_q;
    logic [`SLD_OP_W-1:0] result_q;
    logic [`SLD_OP_W-1:0] result_d;
    logic [3:0]           mask_q;
    logic [3:0]           mask_d;
    logic                 low_ok;
    logic                 high_ok;

    // no low word in beat 0; slide-down keeps the zero high word of the last beat
    assign low_ok  = ~stage_i.first;
    assign high_ok = ~stage_i.last | (stage_i.mode == SLD_DOWN);

    always_comb begin
        logic [2:0] idx;
        for (int i = 0; i < 4; i++) begin
            idx = {1'b0, stage_i.op_shift} + 3'(i);
            if (!idx[2]) begin
                result_d[i*8 +: 8] = op_low_i[idx[1:0]*8 +: 8];
                mask_d[i]          = low_ok;
            end else begin
                result_d[i*8 +: 8] = op_high_i[idx[1:0]*8 +: 8];
                mask_d[i]          = high_ok;
            end
        end
    end

    assign stage_ready_o = ~valid_q | stage_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (stage_ready_o) begin
            valid_q <= stage_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_ready_o & stage_valid_i) begin
            stage_q  <= stage_i;
            result_q <= result_d;
            mask_q   <= mask_d;
        end
    end

    assign stage_o       = stage_q;
    assign stage_valid_o = valid_q;
    assign result_o      = result_q;
    assign result_mask_o = mask_q;

endmodule

/* hw/sld_ctrl_fsm.sv */
////////////////////////////////////////////////////////////
// one command at a time; a new one is taken in the last beat
// slide-down whole-word offsets are applied in the operand stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sld_params.svh"

module sld_ctrl_fsm (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  sld_pkg::sld_cmd_t      cmd_i,
    input  logic                   cmd_valid_i,
    output logic                   cmd_ready_o,
    input  logic                   pipe_ready_i,
    input  logic                   beat_last_i,
    input  sld_pkg::sld_beat_u     beat_i,
    input  sld_pkg::sld_beat_u     store_i,
    output sld_pkg::sld_beat_u     store_init_o,
    output sld_pkg::sld_stage_t    stage_o,
    output logic                   stage_valid_o,
    output logic [`SLD_VREG_W-1:0] vs2_o,
    output logic                   beat_start_o,
    output logic                   beat_step_o
);

    import sld_pkg::*;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } state_e;

    state_e     state_q;
    sld_cmd_t   cmd_q;
    logic [1:0] op_shift_q;
    logic [1:0] op_shift_d;
    sld_off_t   off;
    logic       accept;

    assign off = sld_off_decode(cmd_i.sew, cmd_i.rs1);

    // store count start and in-word shift
    always_comb begin
        if (cmd_i.mode == SLD_UP) begin
            store_init_o.val = {1'b0, off.bytes[3:2]} - ((off.bytes[1:0] == 2'b00) ? 3'd1 : 3'd0);
            op_shift_d       = -off.bytes[1:0];
        end else begin
            // source is pre-shifted by whole words, so only word 0 is inverted
            store_init_o.val = {1'b1, ~2'b00};
            op_shift_d       = off.bytes[1:0];
        end
        if (!off.valid) begin
            if (cmd_i.mode == SLD_UP) begin
                store_init_o.val = 3'b100;
            end
            op_shift_d = 2'b00;
        end
    end

    assign cmd_ready_o  = (state_q == IDLE) | (beat_last_i & pipe_ready_i);
    assign accept       = cmd_valid_i & cmd_ready_o;
    assign beat_start_o = accept;
    assign beat_step_o  = (state_q == RUN) & pipe_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= IDLE;
        end else if (accept) begin
            state_q <= RUN;
        end else if (beat_step_o & beat_last_i) begin
            state_q <= IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q      <= cmd_i;
            op_shift_q <= op_shift_d;
        end
    end

    assign stage_valid_o = state_q == RUN;
    assign vs2_o         = cmd_q.vs2_data;

    always_comb begin
        stage_o.mode      = cmd_q.mode;
        stage_o.sew       = cmd_q.sew;
        stage_o.vl        = cmd_q.vl;
        stage_o.rs1       = cmd_q.rs1;
        stage_o.vd        = cmd_q.vd;
        stage_o.store_cnt = store_i;
        stage_o.op_shift  = op_shift_q;
        stage_o.first     = beat_i.val == 3'd0;
        stage_o.last      = beat_last_i;
        // destination word 3 is complete
        stage_o.store     = ~store_i.part.mul & (store_i.part.low == 2'b11);
    end

endmodule

/* hw/sld_operand_stage.sv */
////////////////////////////////////////////////////////////
// source words leave low first; zeros fill in from the top
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sld_params.svh"

module sld_operand_stage (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  sld_pkg::sld_stage_t    stage_i,
    input  logic                   stage_valid_i,
    output logic                   stage_ready_o,
    input  logic [`SLD_VREG_W-1:0] vs2_i,
    output sld_pkg::sld_stage_t    stage_o,
    output logic                   stage_valid_o,
    input  logic                   stage_ready_i,
    output logic [`SLD_OP_W-1:0]   op_low_o,
    output logic [`SLD_OP_W-1:0]   op_high_o
);

    import sld_pkg::*;

    logic                   valid_q;
    sld_stage_t             stage_q;
    logic [`SLD_VREG_W-1:0] shift_q;
    logic [`SLD_OP_W-1:0]   low_q;
    logic [`SLD_OP_W-1:0]   high_q;
    logic [`SLD_VREG_W-1:0] src;
    sld_off_t               off;
    logic                   load;

    assign off = sld_off_decode(stage_i.sew, stage_i.rs1);

    // slide-down drops whole words here, out of range leaves only zeros
    always_comb begin
        src = vs2_i;
        if (stage_i.mode == SLD_DOWN) begin
            src = off.valid ? (vs2_i >> (off.bytes[3:2] * `SLD_OP_W)) : '0;
        end
    end

    assign stage_ready_o = ~valid_q | stage_ready_i;
    assign load          = stage_ready_o & stage_valid_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (stage_ready_o) begin
            valid_q <= stage_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            stage_q <= stage_i;
            if (stage_i.first) begin
                low_q   <= '0;
                high_q  <= src[`SLD_OP_W-1:0];
                shift_q <= src >> `SLD_OP_W;
            end else begin
                // past the register end the high word is already zero
                low_q   <= high_q;
                high_q  <= shift_q[`SLD_OP_W-1:0];
                shift_q <= shift_q >> `SLD_OP_W;
            end
        end
    end

    assign stage_o       = stage_q;
    assign stage_valid_o = valid_q;
    assign op_low_o      = low_q;
    assign op_high_o     = high_q;

endmodule

/* hw/sld_params.svh */
////////////////////////////////////////////////////////////
// sizes of the slide unit; LMUL is fixed at 1, so one
// destination register is built from SLD_BEATS operand words
////////////////////////////////////////////////////////////

`ifndef SLD_PARAMS_SVH
`define SLD_PARAMS_SVH

// vector register width in bits
`define SLD_VREG_W 128

// operand beat width in bits
`define SLD_OP_W 32

// operand beats per register
`define SLD_BEATS 4

// bytes per register
`define SLD_VMSK_W 16

// vl holds 0 to 16 elements
`define SLD_VL_W 5

`endif

/* hw/sld_pkg.sv */
////////////////////////////////////////////////////////////
// types shared by the slide unit stages
////////////////////////////////////////////////////////////

`include "sld_params.svh"

package sld_pkg;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_mode_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sld_sew_e;

    typedef struct packed {
        sld_mode_e               mode;
        sld_sew_e                sew;
        logic [`SLD_VL_W-1:0]    vl;
        logic [31:0]             rs1;
        logic [`SLD_VREG_W-1:0]  vs2_data;
        logic [4:0]              vd;
    } sld_cmd_t;

    // beat counter, either a plain count or overrun marker plus word position
    typedef union packed {
        logic [2:0] val;
        struct packed {
            logic       mul;
            logic [1:0] low;
        } part;
    } sld_beat_u;

    typedef struct packed {
        sld_mode_e            mode;
        sld_sew_e             sew;
        logic [`SLD_VL_W-1:0] vl;
        logic [31:0]          rs1;
        logic [4:0]           vd;
        sld_beat_u            store_cnt;
        logic [1:0]           op_shift;
        logic                 first;
        logic                 last;
        logic                 store;
    } sld_stage_t;

    typedef struct packed {
        logic [4:0]              addr;
        logic [`SLD_VREG_W-1:0]  data;
        logic [`SLD_VMSK_W-1:0]  mask;
    } sld_wr_t;

    // byte offset of a slide, valid only while it stays inside the register
    typedef struct packed {
        logic       valid;
        logic [3:0] bytes;
    } sld_off_t;

    function automatic sld_off_t sld_off_decode(sld_sew_e sew, logic [31:0] rs1);
        sld_off_t off;
        off.valid = 1'b0;
        off.bytes = rs1[3:0];
        case (sew)
            SEW_8: begin
                off.valid = rs1[31:4] == '0;
                off.bytes = rs1[3:0];
            end
            SEW_16: begin
                off.valid = rs1[31:3] == '0;
                off.bytes = {rs1[2:0], 1'b0};
            end
            SEW_32: begin
                off.valid = rs1[31:2] == '0;
                off.bytes = {rs1[1:0], 2'b00};
            end
            default: ;
        endcase
        return off;
    endfunction

endpackage

/* hw/sld_result_assembler.sv */
////////////////////////////////////////////////////////////
// write is held stable until wr_ready_i; the pipe stalls
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sld_params.svh"

module sld_result_assembler (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  sld_pkg::sld_stage_t  stage_i,
    input  logic                 stage_valid_i,
    output logic                 stage_ready_o,
    input  logic [`SLD_OP_W-1:0] result_i,
    input  logic [3:0]           result_mask_i,
    output sld_pkg::sld_wr_t     wr_o,
    output logic                 wr_valid_o,
    input  logic                 wr_ready_i
);

    import sld_pkg::*;

    logic                   valid_q;
    sld_stage_t             stage_q;
    logic [`SLD_VREG_W-1:0] vd_q;
    logic [`SLD_VMSK_W-1:0] msk_q;
    logic [6:0]             vl_bytes;
    logic [`SLD_VMSK_W-1:0] tail;
    logic [3:0]             tail_part;
    logic                   stall;

    ////////////////////////////////////////////////////////////
    // tail mask

    // bytes below vl times the element size may be written
    assign vl_bytes = {2'b00, stage_i.vl} << stage_i.sew;

    always_comb begin
        if (vl_bytes >= 7'd16) begin
            tail = '1;
        end else begin
            tail = ~({`SLD_VMSK_W{1'b1}} << vl_bytes[3:0]);
        end
    end

    assign tail_part = tail[stage_i.store_cnt.part.low*4 +: 4];

    ////////////////////////////////////////////////////////////
    // destination shift register

    assign stall         = valid_q & stage_q.store & ~wr_ready_i;
    assign stage_ready_o = ~stall;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (stage_ready_o) begin
            valid_q <= stage_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_ready_o & stage_valid_i) begin
            stage_q <= stage_i;
            vd_q    <= {result_i, vd_q[`SLD_VREG_W-1:`SLD_OP_W]};
            // a new command starts with nothing enabled below its first word
            msk_q   <= {result_mask_i & tail_part,
                        stage_i.first ? 12'h000 : msk_q[`SLD_VMSK_W-1:4]};
        end
    end

    assign wr_valid_o = valid_q & stage_q.store;
    assign wr_o.addr  = stage_q.vd;
    assign wr_o.data  = vd_q;
    assign wr_o.mask  = msk_q;

endmodule

/* hw/sld_unit.sv */
////////////////////////////////////////////////////////////
// vector slide unit; vs2 arrives with the command
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sld_params.svh"

module sld_unit (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    input  sld_pkg::sld_cmd_t cmd_i,
    input  logic              cmd_valid_i,
    output logic              cmd_ready_o,
    output sld_pkg::sld_wr_t  wr_o,
    output logic              wr_valid_o,
    input  logic              wr_ready_i
);

    import sld_pkg::*;

    sld_stage_t             st_init, st_op, st_res;
    logic                   v_init, v_op, v_res;
    logic                   r_op, r_res, r_asm;
    sld_beat_u              beat, store, store_init;
    logic                   beat_last, beat_start, beat_step;
    logic [`SLD_VREG_W-1:0] vs2;
    logic [`SLD_OP_W-1:0]   op_low, op_high, result;
    logic [3:0]             result_mask;

    sld_ctrl_fsm u_ctrl (
        .clk_i, .async_rst_ni, .cmd_i, .cmd_valid_i, .cmd_ready_o,
        .pipe_ready_i(r_op), .beat_last_i(beat_last), .beat_i(beat), .store_i(store),
        .store_init_o(store_init), .stage_o(st_init), .stage_valid_o(v_init),
        .vs2_o(vs2), .beat_start_o(beat_start), .beat_step_o(beat_step)
    );

    sld_beat_counter u_cnt (
        .clk_i, .async_rst_ni, .start_i(beat_start), .step_i(beat_step),
        .store_init_i(store_init), .beat_o(beat), .store_o(store), .beat_last_o(beat_last)
    );

    sld_operand_stage u_op (
        .clk_i, .async_rst_ni, .stage_i(st_init), .stage_valid_i(v_init),
        .stage_ready_o(r_op), .vs2_i(vs2), .stage_o(st_op), .stage_valid_o(v_op),
        .stage_ready_i(r_res), .op_low_o(op_low), .op_high_o(op_high)
    );

    sld_byte_shifter u_shift (
        .clk_i, .async_rst_ni, .stage_i(st_op), .stage_valid_i(v_op),
        .stage_ready_o(r_res), .op_low_i(op_low), .op_high_i(op_high), .stage_o(st_res),
        .stage_valid_o(v_res), .stage_ready_i(r_asm), .result_o(result),
        .result_mask_o(result_mask)
    );

    sld_result_assembler u_asm (
        .clk_i, .async_rst_ni, .stage_i(st_res), .stage_valid_i(v_res),
        .stage_ready_o(r_asm), .result_i(result), .result_mask_i(result_mask),
        .wr_o, .wr_valid_o, .wr_ready_i
    );

endmodule
